// ==== Makefile ====
# Build and run the memory stage testbench with Verilator
TOP = tb_mmu

.PHONY: sim clean

sim:
	verilator --binary --assert -j 0 --top-module $(TOP) -f src.f -o sim_$(TOP)
	out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// ==== mmu_access.sv ====
// Stage 2 of the memory stage: store access and return data select
// Stores read at the edge after decode, so instr and data lag the inputs by two
// data holds its last read value, data_valid pulses once per read
// Faulting reads and fetches return zero
`timescale 1ns/100ps

module mmu_access import mmu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        spec_wr,
  input  logic        lin_wr,
  input  logic        rd_go,
  input  logic        rd_special,
  input  logic        rd_fault,
  input  spec_index_t spec_index,
  input  lin_index_t  lin_index,
  input  word_t       wr_data,
  input  lin_index_t  instr_index,
  input  logic        instr_fault,
  output word_t       instr,
  output word_t       data,
  output logic        data_valid
);

  word_t spec_q;       // Special register read data
  word_t lin_data_q;   // Linear memory data port
  word_t lin_instr_q;  // Linear memory fetch port
  word_t data_sel;
  word_t data_last;    // Value shown between reads
  logic  rd_go_q;
  logic  rd_special_q;
  logic  rd_fault_q;
  logic  instr_ok_q;

  mmu_special_regs special_i (
    .clk      (clk),
    .reset    (reset),
    .wr_en    (spec_wr),
    .wr_index (spec_index),
    .wr_data  (wr_data),
    .rd_index (spec_index),
    .rd_data  (spec_q)
  );

  mmu_linear_mem linear_i (
    .clk         (clk),
    .wr_en       (lin_wr),
    .wr_index    (lin_index),
    .wr_data     (wr_data),
    .data_index  (lin_index),
    .instr_index (instr_index),
    .data_q      (lin_data_q),
    .instr_q     (lin_instr_q)
  );

  // Control flags travel alongside the synchronous reads
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_go_q      <= 1'b0;
      rd_special_q <= 1'b0;
      rd_fault_q   <= 1'b0;
      instr_ok_q   <= 1'b0;  // Forces instr to zero until the first fetch
      data_last    <= '0;
    end else begin
      rd_go_q      <= rd_go;
      rd_special_q <= rd_special;
      rd_fault_q   <= rd_fault;
      instr_ok_q   <= !instr_fault;
      if (rd_go_q) data_last <= data_sel;
    end
  end

  assign data_sel   = rd_fault_q ? '0 : (rd_special_q ? spec_q : lin_data_q);
  assign data       = rd_go_q ? data_sel : data_last;
  assign data_valid = rd_go_q;
  assign instr      = instr_ok_q ? lin_instr_q : '0;

  // A faulting read is still a read and must come with rd_go
  a_fault_has_go: assert property (@(posedge clk) disable iff (reset)
    rd_fault |-> rd_go);

endmodule

// ==== mmu_decode.sv ====
// Stage 1 of the memory stage: address decode, faults and plot commands
// All outputs are registered, so they appear one cycle after the inputs
// rd and wd must never be high together
// Fetch faults are evaluated every cycle, data faults only on rd or wd
`timescale 1ns/100ps

module mmu_decode import mmu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  word_t       instr_addr,  // Fetch address
  input  word_t       data_addr,   // Data access address
  input  word_t       data_in,     // Write data
  input  logic        rd,          // Data read strobe
  input  logic        wd,          // Data write strobe
  output logic        instr_segv,
  output logic        data_segv,
  output vga_x_t      vga_x,
  output vga_y_t      vga_y,
  output color_t      vga_color,
  output logic        vga_plot,
  output logic        spec_wr,     // Write strobe to special registers
  output logic        lin_wr,      // Write strobe to linear memory
  output logic        rd_go,       // A data read is in flight
  output logic        rd_special,  // Read source is a special register
  output logic        rd_fault,    // The read faulted, return zero
  output spec_index_t spec_index,
  output lin_index_t  lin_index,
  output word_t       wr_data,
  output lin_index_t  instr_index,
  output logic        instr_fault
);

  word_t instr_off; // Fetch address relative to linear base
  word_t data_off;  // Data address relative to linear base
  logic  instr_boot;
  logic  instr_linear;
  logic  data_special;
  logic  data_linear;
  logic  data_vga;
  logic  data_bad;
  logic  instr_fault_q;

  assign instr_off = instr_addr - LINEAR_BASE;
  assign data_off  = data_addr - LINEAR_BASE;

  // Addresses below the base wrap high, so one compare covers both ends
  assign instr_boot   = (instr_addr == '0);
  assign instr_linear = (instr_off < word_t'(LINEAR_WORDS));

  assign data_special = (data_addr != '0) && (data_addr < LINEAR_BASE);
  assign data_linear  = (data_off < word_t'(LINEAR_WORDS));
  assign data_vga     = (data_addr[31:17] == VGA_PAGE);

  // Only a write may land in the display window, reads there fault
  assign data_bad = !(data_special || data_linear || (data_vga && wd));

  // Control registers
  always_ff @(posedge clk) begin
    if (reset) begin
      instr_fault_q <= 1'b0;
      data_segv     <= 1'b0;
      vga_plot      <= 1'b0;
      spec_wr       <= 1'b0;
      lin_wr        <= 1'b0;
      rd_go         <= 1'b0;
      rd_special    <= 1'b0;
      rd_fault      <= 1'b0;
    end else begin
      instr_fault_q <= !(instr_boot || instr_linear);
      data_segv     <= (rd || wd) && data_bad;
      vga_plot      <= wd && data_vga;
      spec_wr       <= wd && data_special;
      lin_wr        <= wd && data_linear;
      rd_go         <= rd;
      rd_special    <= data_special;
      rd_fault      <= rd && data_bad;
    end
  end

  // Payload registers, meaningful only beside their strobes
  always_ff @(posedge clk) begin
    spec_index  <= spec_index_t'(data_addr - 32'd1);
    lin_index   <= lin_index_t'(data_off);
    wr_data     <= data_in;
    instr_index <= instr_boot ? '0 : lin_index_t'(instr_off); // Boot vector is word 0
    vga_x       <= data_addr[8:0];
    vga_y       <= data_addr[16:9];
    vga_color   <= data_in[23:0];
  end

  assign instr_segv  = instr_fault_q;
  assign instr_fault = instr_fault_q; // Same flag also steers the fetch mux in stage 2

  // Input contract from the core
  a_rd_wd_excl: assert property (@(posedge clk) disable iff (reset) !(rd && wd));

  // One write reaches at most one store in stage 2
  a_wr_onehot: assert property (@(posedge clk) disable iff (reset) !(lin_wr && spec_wr));

endmodule

// ==== mmu_linear_mem.sv ====
// Linear memory of 128 words, one write port and two registered read ports
// Reads are read-before-write: a read on the write edge returns the old word
// Contents start at zero in simulation and survive reset
`timescale 1ns/100ps

module mmu_linear_mem import mmu_pkg::*; (
  input  logic       clk,
  input  logic       wr_en,
  input  lin_index_t wr_index,
  input  word_t      wr_data,
  input  lin_index_t data_index,  // Data read port
  input  lin_index_t instr_index, // Fetch read port
  output word_t      data_q,
  output word_t      instr_q
);

  word_t mem [LINEAR_WORDS];

  // Start of simulation only
  initial begin
    for (int i = 0; i < LINEAR_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // Write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_index] <= wr_data;
    end
  end

  // Data read port
  always_ff @(posedge clk) begin
    data_q <= mem[data_index];  // Old word if written this edge
  end

  // Fetch read port, runs every cycle
  always_ff @(posedge clk) begin
    instr_q <= mem[instr_index];
  end

endmodule

// ==== mmu_pkg.sv ====
// Address map and width types for the memory stage
// Linear memory is 128 words at addresses 16 to 143, special registers at 1 to 15
// Address 0 is reserved for data and is the boot vector for fetches
package mmu_pkg;

  // Plain vector types for widths with a meaning
  typedef logic [31:0] word_t;       // Address or data word
  typedef logic [6:0]  lin_index_t;  // Word index into linear memory
  typedef logic [3:0]  spec_index_t; // Special register index, address minus 1
  typedef logic [8:0]  vga_x_t;      // Plot column
  typedef logic [7:0]  vga_y_t;      // Plot row
  typedef logic [23:0] color_t;      // Plot colour, 8 bits per channel

  // First linear address; everything below it but 0 is a special register
  localparam word_t LINEAR_BASE = 32'd16;

  // Linear memory depth in words
  localparam int unsigned LINEAR_WORDS = 128;

  // Special registers at addresses 1 to 15
  localparam int unsigned SPECIAL_COUNT = 15;

  // Value of address bits 31:17 that selects the display window
  localparam logic [14:0] VGA_PAGE = 15'd1;

endpackage

// ==== mmu_special_regs.sv ====
// Fifteen special registers, cleared by reset
// Read is registered and returns the value before a write on the same edge
// An index of 15 or above reads zero
`timescale 1ns/100ps

module mmu_special_regs import mmu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        wr_en,
  input  spec_index_t wr_index,
  input  word_t       wr_data,
  input  spec_index_t rd_index,
  output word_t       rd_data
);

  word_t regs [SPECIAL_COUNT];

  // Register file, reset clears every entry
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < SPECIAL_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_index] <= wr_data;
    end
  end

  // Read port sees the old contents on a write edge
  always_ff @(posedge clk) begin
    if (rd_index < spec_index_t'(SPECIAL_COUNT)) begin
      rd_data <= regs[rd_index];
    end else begin
      rd_data <= '0;  // Index 15 has no register behind it
    end
  end

  // Decode only writes here for addresses 1 to 15
  a_wr_range: assert property (@(posedge clk) disable iff (reset)
    wr_en |-> (wr_index < spec_index_t'(SPECIAL_COUNT)));

endmodule

// ==== mmu_top.sv ====
// Memory stage top: decode stage followed by access stage
// Fault and plot outputs lag the inputs by one cycle, instr and data by two
// No back-pressure, every access completes at fixed latency
`timescale 1ns/100ps

module mmu_top import mmu_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  word_t  instr_addr,
  input  word_t  data_addr,
  input  word_t  data_in,
  input  logic   rd,
  input  logic   wd,
  output word_t  instr,
  output word_t  data,
  output logic   data_valid,
  output logic   instr_segv,
  output logic   data_segv,
  output vga_x_t vga_x,
  output vga_y_t vga_y,
  output color_t vga_color,
  output logic   vga_plot
);

  logic        spec_wr;
  logic        lin_wr;
  logic        rd_go;
  logic        rd_special;
  logic        rd_fault;
  spec_index_t spec_index;
  lin_index_t  lin_index;
  word_t       wr_data;
  lin_index_t  instr_index;
  logic        instr_fault;

  mmu_decode decode_i (
    .clk         (clk),
    .reset       (reset),
    .instr_addr  (instr_addr),
    .data_addr   (data_addr),
    .data_in     (data_in),
    .rd          (rd),
    .wd          (wd),
    .instr_segv  (instr_segv),
    .data_segv   (data_segv),
    .vga_x       (vga_x),
    .vga_y       (vga_y),
    .vga_color   (vga_color),
    .vga_plot    (vga_plot),
    .spec_wr     (spec_wr),
    .lin_wr      (lin_wr),
    .rd_go       (rd_go),
    .rd_special  (rd_special),
    .rd_fault    (rd_fault),
    .spec_index  (spec_index),
    .lin_index   (lin_index),
    .wr_data     (wr_data),
    .instr_index (instr_index),
    .instr_fault (instr_fault)
  );

  mmu_access access_i (
    .clk         (clk),
    .reset       (reset),
    .spec_wr     (spec_wr),
    .lin_wr      (lin_wr),
    .rd_go       (rd_go),
    .rd_special  (rd_special),
    .rd_fault    (rd_fault),
    .spec_index  (spec_index),
    .lin_index   (lin_index),
    .wr_data     (wr_data),
    .instr_index (instr_index),
    .instr_fault (instr_fault),
    .instr       (instr),
    .data        (data),
    .data_valid  (data_valid)
  );

endmodule

// ==== src.f ====
mmu_pkg.sv
mmu_decode.sv
mmu_special_regs.sv
mmu_linear_mem.sv
mmu_access.sv
mmu_top.sv
tb_mmu.sv

// ==== tb_mmu.sv ====
// Testbench for the memory stage, table of operations applied in order
// Inputs change 2 ns after the rising edge, outputs are sampled 2 ns after an edge
// Expected data comes from reference copies of linear memory and special registers
// Random pass uses $urandom seeded once at the start of the run
`timescale 1ns/100ps

module tb_mmu import mmu_pkg::*; ();

  localparam logic [1:0] OP_WRITE = 2'd0;
  localparam logic [1:0] OP_READ  = 2'd1;
  localparam logic [1:0] OP_FETCH = 2'd2;

  typedef struct packed {
    logic [1:0] kind;
    word_t      addr;
    word_t      wdata;
    logic       fault;  // Expected data_segv or instr_segv
    logic       plot;   // Expected vga_plot
    vga_x_t     x;
    vga_y_t     y;
    color_t     color;
  } op_t;

  logic   clk;
  logic   reset;
  word_t  instr_addr;
  word_t  data_addr;
  word_t  data_in;
  logic   rd;
  logic   wd;
  word_t  instr;
  word_t  data;
  logic   data_valid;
  logic   instr_segv;
  logic   data_segv;
  vga_x_t vga_x;
  vga_y_t vga_y;
  color_t vga_color;
  logic   vga_plot;

  op_t   ops [$];               // Stimulus table
  word_t ref_lin [LINEAR_WORDS];
  word_t ref_spec [SPECIAL_COUNT];
  int    checks;
  int    errors;
  int    timeouts;

  mmu_top mmu_top_i (
    .clk        (clk),
    .reset      (reset),
    .instr_addr (instr_addr),
    .data_addr  (data_addr),
    .data_in    (data_in),
    .rd         (rd),
    .wd         (wd),
    .instr      (instr),
    .data       (data),
    .data_valid (data_valid),
    .instr_segv (instr_segv),
    .data_segv  (data_segv),
    .vga_x      (vga_x),
    .vga_y      (vga_y),
    .vga_color  (vga_color),
    .vga_plot   (vga_plot)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  function automatic logic is_special(input word_t addr);
    return (addr >= 32'd1) && (addr < LINEAR_BASE);
  endfunction

  function automatic logic is_linear(input word_t addr);
    return (addr >= LINEAR_BASE) && (addr < LINEAR_BASE + word_t'(LINEAR_WORDS));
  endfunction

  // Writes land only in special or linear space, plots store nothing
  function automatic void update_ref(input word_t addr, input word_t wdata);
    if (is_special(addr)) ref_spec[spec_index_t'(addr - 32'd1)] = wdata;
    else if (is_linear(addr)) ref_lin[lin_index_t'(addr - LINEAR_BASE)] = wdata;
  endfunction

  function automatic word_t ref_data(input word_t addr);
    if (is_special(addr)) return ref_spec[spec_index_t'(addr - 32'd1)];
    if (is_linear(addr)) return ref_lin[lin_index_t'(addr - LINEAR_BASE)];
    return '0;
  endfunction

  function automatic word_t ref_instr(input word_t addr);
    if (addr == '0) return ref_lin[0];  // Boot vector
    if (is_linear(addr)) return ref_lin[lin_index_t'(addr - LINEAR_BASE)];
    return '0;
  endfunction

  function automatic void add_op(input logic [1:0] kind, input word_t addr, input word_t wdata,
                                 input logic fault, input logic plot = 1'b0,
                                 input vga_x_t x = '0, input vga_y_t y = '0,
                                 input color_t color = '0);
    op_t op;
    op.kind  = kind;
    op.addr  = addr;
    op.wdata = wdata;
    op.fault = fault;
    op.plot  = plot;
    op.x     = x;
    op.y     = y;
    op.color = color;
    ops.push_back(op);
  endfunction

  task automatic check_word(input string what, input word_t got, input word_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("error at %0d ns: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("error at %0d ns: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  task automatic check_plot(input vga_x_t x, input vga_y_t y, input color_t c,
                            input vga_x_t wx, input vga_y_t wy, input color_t wc);
    checks++;
    if (x !== wx || y !== wy || c !== wc) begin
      errors++;
      $display("error at %0d ns: plot at (%h,%h) colour %h, expected (%h,%h) colour %h",
               $time, x, y, c, wx, wy, wc);
    end
  endtask

  // Called 2 ns after an edge, returns 2 ns after the edge that sampled the write
  task automatic write_word(input word_t addr, input word_t wdata, input logic fault,
                            input logic plot, input vga_x_t x, input vga_y_t y,
                            input color_t c);
    data_addr = addr;
    data_in   = wdata;
    wd        = 1'b1;
    @(posedge clk);
    #2;
    wd = 1'b0;
    check_flag(data_segv, fault, $sformatf("data_segv on write to %h", addr));
    check_flag(vga_plot, plot, $sformatf("vga_plot on write to %h", addr));
    if (plot) check_plot(vga_x, vga_y, vga_color, x, y, c);
    update_ref(addr, wdata);
  endtask

  task automatic read_word(input word_t addr, input logic fault);
    word_t want;
    int    waited;
    want      = fault ? '0 : ref_data(addr);  // Faulting reads return zero
    data_addr = addr;
    rd        = 1'b1;
    @(posedge clk);
    #2;
    rd = 1'b0;
    check_flag(data_segv, fault, $sformatf("data_segv on read of %h", addr));
    waited = 0;
    while (!data_valid && waited < 20) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!data_valid) begin
      timeouts++;
      $display("Read of address %h never raised data_valid within 20 cycles", addr);
    end else begin
      check_word($sformatf("data from %h", addr), data, want);
    end
  endtask

  // Fetch latency is fixed, segv after one edge and instr after two
  task automatic fetch_word(input word_t addr, input logic fault);
    word_t want;
    want       = fault ? '0 : ref_instr(addr);
    instr_addr = addr;
    @(posedge clk);
    #2;
    check_flag(instr_segv, fault, $sformatf("instr_segv on fetch of %h", addr));
    @(posedge clk);
    #2;
    check_word($sformatf("instr from %h", addr), instr, want);
  endtask

  task automatic apply_op(input op_t op);
    case (op.kind)
      OP_WRITE: write_word(op.addr, op.wdata, op.fault, op.plot, op.x, op.y, op.color);
      OP_READ:  read_word(op.addr, op.fault);
      default:  fetch_word(op.addr, op.fault);
    endcase
  endtask

  function automatic void build_table();
    for (int a = 1; a <= 15; a++) add_op(OP_READ, word_t'(a), '0, 1'b0);  // Cleared by reset
    add_op(OP_READ, 32'd16, '0, 1'b0);
    add_op(OP_READ, 32'd80, '0, 1'b0);
    add_op(OP_READ, 32'd143, '0, 1'b0);
    add_op(OP_FETCH, 32'd0, '0, 1'b0);
    // Write then read on the very next cycle
    add_op(OP_WRITE, 32'd3, 32'hdeadbeef, 1'b0);
    add_op(OP_READ, 32'd3, '0, 1'b0);
    add_op(OP_WRITE, 32'd15, 32'h0f0f1234, 1'b0);
    add_op(OP_READ, 32'd15, '0, 1'b0);
    add_op(OP_WRITE, 32'd1, 32'h11111111, 1'b0);
    add_op(OP_READ, 32'd1, '0, 1'b0);
    add_op(OP_WRITE, 32'd16, 32'h12345678, 1'b0);
    add_op(OP_READ, 32'd16, '0, 1'b0);
    add_op(OP_WRITE, 32'd143, 32'hcafef00d, 1'b0);
    add_op(OP_READ, 32'd143, '0, 1'b0);
    add_op(OP_WRITE, 32'd77, 32'ha5a55a5a, 1'b0);
    add_op(OP_READ, 32'd77, '0, 1'b0);
    add_op(OP_READ, 32'd3, '0, 1'b0);
    // Faulting data accesses
    add_op(OP_READ, 32'd0, '0, 1'b1);
    add_op(OP_WRITE, 32'd0, 32'h99999999, 1'b1);
    add_op(OP_READ, 32'd16, '0, 1'b0);  // Still the old word
    add_op(OP_READ, 32'd144, '0, 1'b1);
    add_op(OP_WRITE, 32'd144, 32'h77777777, 1'b1);
    add_op(OP_READ, 32'd143, '0, 1'b0);
    add_op(OP_READ, 32'hffffffff, '0, 1'b1);
    add_op(OP_READ, 32'h00020010, '0, 1'b1);  // Display window is write only
    add_op(OP_WRITE, 32'h00040000, 32'h12121212, 1'b1);
    // Plot commands, low address bits alias linear word 0
    add_op(OP_WRITE, 32'h00020010, 32'h55aa33cc, 1'b0, 1'b1, 9'h010, 8'h00, 24'haa33cc);
    add_op(OP_READ, 32'd16, '0, 1'b0);
    add_op(OP_WRITE, 32'h000279a5, 32'hff123456, 1'b0, 1'b1, 9'h1a5, 8'h3c, 24'h123456);
    add_op(OP_WRITE, 32'h0003ffff, 32'h00abcdef, 1'b0, 1'b1, 9'h1ff, 8'hff, 24'habcdef);
    // Fetches
    add_op(OP_FETCH, 32'd0, '0, 1'b0);
    add_op(OP_FETCH, 32'd16, '0, 1'b0);
    add_op(OP_FETCH, 32'd143, '0, 1'b0);
    add_op(OP_FETCH, 32'd77, '0, 1'b0);
    add_op(OP_FETCH, 32'd1, '0, 1'b1);
    add_op(OP_FETCH, 32'd15, '0, 1'b1);
    add_op(OP_FETCH, 32'd144, '0, 1'b1);
    add_op(OP_FETCH, 32'h00020000, '0, 1'b1);
    add_op(OP_FETCH, 32'd0, '0, 1'b0);
  endfunction

  initial begin
    word_t addr;
    void'($urandom(20753));
    reset      = 1'b1;
    instr_addr = '0;
    data_addr  = '0;
    data_in    = '0;
    rd         = 1'b0;
    wd         = 1'b0;
    checks     = 0;
    errors     = 0;
    timeouts   = 0;
    for (int i = 0; i < LINEAR_WORDS; i++) ref_lin[i] = '0;
    for (int i = 0; i < SPECIAL_COUNT; i++) ref_spec[i] = '0;
    build_table();
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    // Output state straight after reset
    check_flag(data_valid, 1'b0, "data_valid after reset");
    check_flag(vga_plot, 1'b0, "vga_plot after reset");
    check_flag(data_segv, 1'b0, "data_segv after reset");
    check_flag(instr_segv, 1'b0, "instr_segv after reset");
    check_word("instr after reset", instr, '0);
    check_word("data after reset", data, '0);
    for (int i = 0; i < ops.size(); i++) apply_op(ops[i]);
    // Random write and read-back over linear memory
    for (int n = 0; n < 48; n++) begin
      addr = LINEAR_BASE + word_t'($urandom % LINEAR_WORDS);
      write_word(addr, $urandom, 1'b0, 1'b0, '0, '0, '0);
      read_word(addr, 1'b0);
    end
    for (int i = 0; i < LINEAR_WORDS; i++) read_word(LINEAR_BASE + word_t'(i), 1'b0);
    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
